/* mips_pipe.f */
src/mips_pkg.sv
src/pc_fetch.sv
src/pipe_reg.sv
src/reg_file.sv
src/decode_stage.sv
src/execute_stage.sv
src/mips_pipe.sv
tb/tb_mips_pipe.sv

/* src/decode_stage.sv */
`default_nettype none

module decode_stage import mips_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    cpu_en,
    input  if_id_t  if_id,
    input  id_ex_t  ex_stage,
    input  word_t   ex_result,
    input  ex_mem_t ex_mem,
    input  word_t   data_rdata,
    input  mem_wb_t mem_wb,
    output id_ex_t  id_ex,
    output logic    stall,
    output logic    redirect,
    output word_t   redirect_pc
);

    logic [5:0] opcode;
    logic [5:0] funct;
    reg_addr_t  rs;
    reg_addr_t  rt;
    reg_addr_t  rd;
    word_t      imm_sext;
    word_t      imm_zext;
    ctrl_t      ctrl;
    reg_addr_t  dest;
    word_t      imm;
    logic       uses_rs;
    logic       uses_rt;
    word_t      rf_rs;
    word_t      rf_rt;
    word_t      rs_value;
    word_t      rt_value;
    word_t      wb_data;
    logic       load_in_ex;
    logic       hit_rs;
    logic       hit_rt;
    logic       store_fwd;
    logic       branch_taken;

    assign opcode   = if_id.instr[31:26];
    assign rs       = if_id.instr[25:21];
    assign rt       = if_id.instr[20:16];
    assign rd       = if_id.instr[15:11];
    assign funct    = if_id.instr[5:0];
    assign imm_sext = {{16{if_id.instr[15]}}, if_id.instr[15:0]};
    assign imm_zext = {16'h0000, if_id.instr[15:0]};

    always_comb begin
        ctrl    = '0;
        dest    = rt;
        imm     = imm_sext;
        uses_rs = 1'b1;
        uses_rt = 1'b0;
        case (opcode)
            OP_RTYPE: begin
                ctrl.reg_write = 1'b1;
                dest           = rd;
                uses_rt        = 1'b1;
                case (funct)
                    FN_ADDU: ctrl.alu_op = ALU_ADD;
                    FN_SUBU: ctrl.alu_op = ALU_SUB;
                    FN_AND:  ctrl.alu_op = ALU_AND;
                    FN_OR:   ctrl.alu_op = ALU_OR;
                    FN_XOR:  ctrl.alu_op = ALU_XOR;
                    FN_SLT:  ctrl.alu_op = ALU_SLT;
                    FN_SLL: begin
                        ctrl.alu_op        = ALU_SLL;
                        ctrl.alu_src_shamt = 1'b1;
                        uses_rs            = 1'b0;
                    end
                    FN_SRL: begin
                        ctrl.alu_op        = ALU_SRL;
                        ctrl.alu_src_shamt = 1'b1;
                        uses_rs            = 1'b0;
                    end
                    default: ctrl.reg_write = 1'b0;
                endcase
            end
            OP_ADDIU, OP_LW: begin
                ctrl.reg_write   = 1'b1;
                ctrl.mem_to_reg  = (opcode == OP_LW);
                ctrl.alu_src_imm = 1'b1;
                ctrl.alu_op      = ALU_ADD;
            end
            OP_ANDI, OP_ORI: begin
                ctrl.reg_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                ctrl.alu_op      = (opcode == OP_ANDI) ? ALU_AND : ALU_OR;
                imm              = imm_zext;
            end
            OP_LUI: begin
                ctrl.reg_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                ctrl.alu_op      = ALU_LUI;
                uses_rs          = 1'b0;
            end
            OP_SW: begin
                ctrl.mem_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                ctrl.alu_op      = ALU_ADD;
                uses_rt          = 1'b1;
            end
            OP_BEQ, OP_BNE: uses_rt = 1'b1;
            default: uses_rs = 1'b0;
        endcase
        // r0 is never a real destination
        if (dest == '0) begin
            ctrl.reg_write = 1'b0;
        end
    end

    assign wb_data = mem_wb.mem_to_reg ? mem_wb.load_data : mem_wb.alu_result;

    reg_file u_reg_file (
        .clk     (clk),
        .rst     (rst),
        .rs_addr (rs),
        .rt_addr (rt),
        .we      (mem_wb.reg_write && cpu_en),
        .wr_addr (mem_wb.dest),
        .wr_data (wb_data),
        .rs_data (rf_rs),
        .rt_data (rf_rt)
    );

    // newest producer wins: execute, then memory stage, then register file
    function automatic word_t fwd(input reg_addr_t src, input word_t rf_value);
        word_t value;
        value = rf_value;
        if (ex_mem.ctrl.reg_write && ex_mem.dest == src) begin
            value = ex_mem.ctrl.mem_to_reg ? data_rdata : ex_mem.alu_result;
        end
        if (ex_stage.ctrl.reg_write && !ex_stage.ctrl.mem_to_reg && ex_stage.dest == src) begin
            value = ex_result;
        end
        return value;
    endfunction

    always_comb begin
        rs_value = fwd(rs, rf_rs);
        rt_value = fwd(rt, rf_rt);
    end

    // load in execute cannot forward yet
    assign load_in_ex = ex_stage.ctrl.reg_write && ex_stage.ctrl.mem_to_reg;
    assign hit_rs     = uses_rs && ex_stage.dest == rs;
    assign hit_rt     = uses_rt && ex_stage.dest == rt;
    assign store_fwd  = load_in_ex && hit_rt && !hit_rs && opcode == OP_SW;
    assign stall      = load_in_ex && (hit_rs || (hit_rt && opcode != OP_SW));

    assign branch_taken = (opcode == OP_BEQ && rs_value == rt_value)
                       || (opcode == OP_BNE && rs_value != rt_value);
    // branch waits while a load in execute still owes it an operand
    assign redirect     = (branch_taken && !(load_in_ex && (hit_rs || hit_rt)))
                       || opcode == OP_J;
    assign redirect_pc  = (opcode == OP_J)
                        ? {if_id.pc_plus4[31:28], if_id.instr[25:0], 2'b00}
                        : if_id.pc_plus4 + {imm_sext[29:0], 2'b00};

    assign id_ex = '{
        ctrl:                ctrl,
        rs_value:            rs_value,
        rt_value:            rt_value,
        imm:                 imm,
        shamt:               {27'b0, if_id.instr[10:6]},
        dest:                dest,
        store_fwd_from_load: store_fwd
    };

    a_stall_redirect: assert property (@(posedge clk) disable iff (rst)
        !(stall && redirect))
        else $error("stall and redirect together");

    // the flushed bubble in execute clears the hazard on the next cycle
    a_stall_one_cycle: assert property (@(posedge clk) disable iff (rst)
        stall && cpu_en |=> !stall)
        else $error("load-use stall longer than one cycle");

endmodule

`default_nettype wire

/* src/execute_stage.sv */
`default_nettype none

module execute_stage import mips_pkg::*; (
    input  id_ex_t  id_ex,
    input  word_t   data_rdata,
    output ex_mem_t ex_mem,
    output word_t   alu_result
);

    word_t a;
    word_t b;
    word_t store_data;

    assign a = id_ex.ctrl.alu_src_shamt ? id_ex.shamt : id_ex.rs_value;
    assign b = id_ex.ctrl.alu_src_imm ? id_ex.imm : id_ex.rt_value;

    always_comb begin
        case (id_ex.ctrl.alu_op)
            ALU_ADD: alu_result = a + b;
            ALU_SUB: alu_result = a - b;
            ALU_AND: alu_result = a & b;
            ALU_OR:  alu_result = a | b;
            ALU_XOR: alu_result = a ^ b;
            ALU_SLT: alu_result = {31'b0, $signed(a) < $signed(b)};
            ALU_SLL: alu_result = b << a[4:0];
            ALU_SRL: alu_result = b >> a[4:0];
            ALU_LUI: alu_result = {b[15:0], 16'h0000};
            default: alu_result = '0;
        endcase
    end

    // load directly ahead is now in the memory stage
    assign store_data = id_ex.store_fwd_from_load ? data_rdata : id_ex.rt_value;

    assign ex_mem = '{
        ctrl:       id_ex.ctrl,
        alu_result: alu_result,
        store_data: store_data,
        dest:       id_ex.dest
    };

endmodule

`default_nettype wire

/* src/mips_pipe.sv */
`default_nettype none

module mips_pipe import mips_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  cpu_en,
    input  word_t instr,
    input  word_t data_rdata,
    output word_t pc,
    output word_t data_addr,
    output word_t data_wdata,
    output logic  data_we
);

    word_t   pc_plus4;
    logic    stall;
    logic    redirect;
    word_t   redirect_pc;
    word_t   ex_result;
    if_id_t  if_id_d;
    if_id_t  if_id_q;
    id_ex_t  id_ex_d;
    id_ex_t  id_ex_q;
    ex_mem_t ex_mem_d;
    ex_mem_t ex_mem_q;
    mem_wb_t mem_wb_d;
    mem_wb_t mem_wb_q;

    pc_fetch u_pc_fetch (
        .clk         (clk),
        .rst         (rst),
        .cpu_en      (cpu_en),
        .stall       (stall),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .pc          (pc),
        .pc_plus4    (pc_plus4)
    );

    assign if_id_d = '{pc_plus4: pc_plus4, instr: instr};

    // taken branch squashes the fetch behind it
    pipe_reg #(.payload_t(if_id_t)) if_id_reg (
        .clk(clk), .rst(rst), .en(cpu_en && !stall), .flush(redirect),
        .d(if_id_d), .q(if_id_q)
    );

    decode_stage u_decode (
        .clk         (clk),
        .rst         (rst),
        .cpu_en      (cpu_en),
        .if_id       (if_id_q),
        .ex_stage    (id_ex_q),
        .ex_result   (ex_result),
        .ex_mem      (ex_mem_q),
        .data_rdata  (data_rdata),
        .mem_wb      (mem_wb_q),
        .id_ex       (id_ex_d),
        .stall       (stall),
        .redirect    (redirect),
        .redirect_pc (redirect_pc)
    );

    // bubble into execute on load-use
    pipe_reg #(.payload_t(id_ex_t)) id_ex_reg (
        .clk(clk), .rst(rst), .en(cpu_en), .flush(stall),
        .d(id_ex_d), .q(id_ex_q)
    );

    execute_stage u_execute (
        .id_ex      (id_ex_q),
        .data_rdata (data_rdata),
        .ex_mem     (ex_mem_d),
        .alu_result (ex_result)
    );

    pipe_reg #(.payload_t(ex_mem_t)) ex_mem_reg (
        .clk(clk), .rst(rst), .en(cpu_en), .flush(1'b0),
        .d(ex_mem_d), .q(ex_mem_q)
    );

    assign data_addr  = ex_mem_q.alu_result;
    assign data_wdata = ex_mem_q.store_data;
    assign data_we    = ex_mem_q.ctrl.mem_write && cpu_en;

    assign mem_wb_d = '{
        reg_write:  ex_mem_q.ctrl.reg_write,
        mem_to_reg: ex_mem_q.ctrl.mem_to_reg,
        alu_result: ex_mem_q.alu_result,
        load_data:  data_rdata,
        dest:       ex_mem_q.dest
    };

    pipe_reg #(.payload_t(mem_wb_t)) mem_wb_reg (
        .clk(clk), .rst(rst), .en(cpu_en), .flush(1'b0),
        .d(mem_wb_d), .q(mem_wb_q)
    );

endmodule

`default_nettype wire

/* src/mips_pkg.sv */
`default_nettype none

package mips_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    localparam word_t RESET_PC = 32'h0000_0000;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLL,
        ALU_SRL,
        ALU_LUI
    } alu_op_e;

    // primary opcodes
    localparam logic [5:0] OP_RTYPE = 6'h00;
    localparam logic [5:0] OP_J     = 6'h02;
    localparam logic [5:0] OP_BEQ   = 6'h04;
    localparam logic [5:0] OP_BNE   = 6'h05;
    localparam logic [5:0] OP_ADDIU = 6'h09;
    localparam logic [5:0] OP_ANDI  = 6'h0c;
    localparam logic [5:0] OP_ORI   = 6'h0d;
    localparam logic [5:0] OP_LUI   = 6'h0f;
    localparam logic [5:0] OP_LW    = 6'h23;
    localparam logic [5:0] OP_SW    = 6'h2b;

    // funct field of r-type
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_SLT  = 6'h2a;
    localparam logic [5:0] FN_SLL  = 6'h00;
    localparam logic [5:0] FN_SRL  = 6'h02;

    typedef struct packed {
        logic    reg_write;
        logic    mem_write;
        logic    mem_to_reg;
        logic    alu_src_imm;
        logic    alu_src_shamt;
        alu_op_e alu_op;
    } ctrl_t;

    typedef struct packed {
        word_t pc_plus4;
        word_t instr;
    } if_id_t;

    typedef struct packed {
        ctrl_t     ctrl;
        word_t     rs_value;
        word_t     rt_value;
        word_t     imm;
        word_t     shamt;
        reg_addr_t dest;
        logic      store_fwd_from_load;
    } id_ex_t;

    typedef struct packed {
        ctrl_t     ctrl;
        word_t     alu_result;
        word_t     store_data;
        reg_addr_t dest;
    } ex_mem_t;

    typedef struct packed {
        logic      reg_write;
        logic      mem_to_reg;
        word_t     alu_result;
        word_t     load_data;
        reg_addr_t dest;
    } mem_wb_t;

endpackage

`default_nettype wire

/* src/pc_fetch.sv */
`default_nettype none

module pc_fetch import mips_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  cpu_en,
    input  logic  stall,
    input  logic  redirect,
    input  word_t redirect_pc,
    output word_t pc,
    output word_t pc_plus4
);

    assign pc_plus4 = pc + 32'd4;

    // a redirect never coincides with a stall, so hold wins
    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= RESET_PC;
        end else if (cpu_en && !stall) begin
            pc <= redirect ? redirect_pc : pc_plus4;
        end
    end

    // branch and jump targets from decode keep the low bits clear
    a_pc_aligned: assert property (@(posedge clk) disable iff (rst)
        pc[1:0] == 2'b00)
        else $error("pc not word aligned: %h", pc);

endmodule

`default_nettype wire

/* src/pipe_reg.sv */
`default_nettype none

module pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     en,
    input  logic     flush,
    input  payload_t d,
    output payload_t q
);

    // all-zero payload is a bubble: no reg_write, no mem_write
    always_ff @(posedge clk) begin
        if (rst) begin
            q <= '0;
        end else if (en) begin
            if (flush) begin
                q <= '0;
            end else begin
                q <= d;
            end
        end
    end

endmodule

`default_nettype wire

/* src/reg_file.sv */
`default_nettype none

module reg_file import mips_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  reg_addr_t rs_addr,
    input  reg_addr_t rt_addr,
    input  logic      we,
    input  reg_addr_t wr_addr,
    input  word_t     wr_data,
    output word_t     rs_data,
    output word_t     rt_data
);

    word_t regs [32];

    always_ff @(posedge clk) begin
        if (rst) begin
            regs <= '{default: '0};
        end else if (we && wr_addr != '0) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // write-through so decode sees the value retiring this cycle
    assign rs_data = (rs_addr == '0) ? '0 :
                     (we && wr_addr == rs_addr) ? wr_data : regs[rs_addr];
    assign rt_data = (rt_addr == '0) ? '0 :
                     (we && wr_addr == rt_addr) ? wr_data : regs[rt_addr];

    // decode drops reg_write for destination zero
    a_no_r0_write: assert property (@(posedge clk) disable iff (rst)
        !(we && wr_addr == '0))
        else $error("write to register zero");

endmodule

`default_nettype wire

/* tb/tb_mips_pipe.sv */
`default_nettype none

module tb_mips_pipe import mips_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int PROG_LEN    = 37;
    localparam int N_STORES    = 10;
    localparam int CYCLE_LIMIT = 8 * PROG_LEN + 50;
    localparam int PAUSE_LEN   = 5;
    localparam word_t LOOP_PC  = 32'd140;

    typedef struct packed {
        word_t addr;
        word_t data;
    } store_t;

    logic  clk;
    logic  rst;
    logic  cpu_en;
    word_t instr;
    word_t data_rdata;
    word_t pc;
    word_t data_addr;
    word_t data_wdata;
    logic  data_we;

    word_t prog [PROG_LEN];
    word_t rom [64];
    word_t ram [64];
    int    store_count;
    int    tests_passed;
    int    tests_failed;
    int    cycle;
    int    pause_start;

    // values follow from running the program by hand, taken path only
    store_t expected [N_STORES] = '{
        '{32'd0,  32'd13},
        '{32'd4,  32'd52},
        '{32'd8,  32'h1234_5678},
        '{32'd12, 32'h0123_4540},
        '{32'd16, 32'd1},
        '{32'd20, 32'd53},
        '{32'd24, 32'd13},
        '{32'd28, 32'h0000_5600},
        '{32'd40, 32'd8},
        '{32'd44, 32'd8}
    };

    mips_pipe UUT (
        .clk        (clk),
        .rst        (rst),
        .cpu_en     (cpu_en),
        .instr      (instr),
        .data_rdata (data_rdata),
        .pc         (pc),
        .data_addr  (data_addr),
        .data_wdata (data_wdata),
        .data_we    (data_we)
    );

    assign instr      = rom[pc[7:2]];
    assign data_rdata = ram[data_addr[7:2]];

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic word_t enc_r(input logic [5:0] fn, input reg_addr_t rs,
                                    input reg_addr_t rt, input reg_addr_t rd,
                                    input logic [4:0] shamt);
        return {OP_RTYPE, rs, rt, rd, shamt, fn};
    endfunction

    function automatic word_t enc_i(input logic [5:0] op, input reg_addr_t rs,
                                    input reg_addr_t rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic word_t enc_j(input logic [25:0] target);
        return {OP_J, target};
    endfunction

    function automatic int unsigned lcg_next(input int unsigned state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic check_store(input int idx, input word_t addr, input word_t data,
                               input store_t exp);
        if (addr !== exp.addr || data !== exp.data) begin
            $display("FAILED at %0t: store %0d wrote %h to %h, expected %h to %h",
                     $time, idx, data, addr, exp.data, exp.addr);
            tests_failed++;
        end else begin
            $display("store %0d ok: %h to %h", idx, data, addr);
            tests_passed++;
        end
    endtask

    task automatic check_pc(input word_t actual, input word_t exp);
        if (actual !== exp) begin
            $display("FAILED at %0t: final pc %h, expected %h", $time, actual, exp);
            tests_failed++;
        end else begin
            $display("final pc ok: %h", actual);
            tests_passed++;
        end
    endtask

    task automatic load_program();
        prog[0]  = enc_i(OP_ADDIU, 0, 1, 16'd5);
        prog[1]  = enc_i(OP_ADDIU, 1, 2, 16'd3);
        prog[2]  = enc_r(FN_ADDU, 1, 2, 3, 0);
        prog[3]  = enc_r(FN_SLL, 0, 3, 4, 5'd2);
        prog[4]  = enc_i(OP_LUI, 0, 5, 16'h1234);
        prog[5]  = enc_i(OP_ORI, 5, 5, 16'h5678);
        prog[6]  = enc_i(OP_SW, 0, 3, 16'd0);
        prog[7]  = enc_i(OP_SW, 0, 4, 16'd4);
        prog[8]  = enc_i(OP_SW, 0, 5, 16'd8);
        prog[9]  = enc_r(FN_SUBU, 4, 3, 6, 0);
        prog[10] = enc_r(FN_SRL, 0, 5, 7, 5'd4);
        prog[11] = enc_r(FN_XOR, 6, 7, 8, 0);
        prog[12] = enc_r(FN_SLT, 6, 4, 9, 0);
        prog[13] = enc_i(OP_SW, 0, 8, 16'd12);
        prog[14] = enc_i(OP_SW, 0, 9, 16'd16);
        // load then immediate user: one stall
        prog[15] = enc_i(OP_LW, 0, 10, 16'd4);
        prog[16] = enc_i(OP_ADDIU, 10, 11, 16'd1);
        prog[17] = enc_i(OP_SW, 0, 11, 16'd20);
        // load then store of the loaded register
        prog[18] = enc_i(OP_LW, 0, 12, 16'd0);
        prog[19] = enc_i(OP_SW, 0, 12, 16'd24);
        prog[20] = enc_i(OP_ANDI, 5, 13, 16'hff00);
        prog[21] = enc_i(OP_BEQ, 1, 1, 16'd2);
        prog[22] = enc_i(OP_SW, 0, 13, 16'd28);
        prog[23] = enc_i(OP_SW, 0, 0, 16'd32);
        prog[24] = enc_i(OP_BNE, 1, 1, 16'd5);
        prog[25] = enc_i(OP_SW, 0, 13, 16'd28);
        prog[26] = enc_i(OP_BNE, 1, 2, 16'd2);
        prog[27] = enc_i(OP_SW, 0, 1, 16'd36);
        prog[28] = enc_i(OP_SW, 0, 2, 16'd36);
        prog[29] = enc_i(OP_BEQ, 1, 2, 16'd3);
        prog[30] = enc_j(26'd32);
        prog[31] = enc_i(OP_SW, 0, 1, 16'd40);
        prog[32] = enc_i(OP_SW, 0, 2, 16'd40);
        prog[33] = enc_r(FN_AND, 3, 5, 14, 0);
        prog[34] = enc_i(OP_SW, 0, 14, 16'd44);
        prog[35] = enc_j(26'd35);
        prog[36] = enc_i(OP_SW, 0, 1, 16'd48);
    endtask

    // store checker and data RAM write
    always @(posedge clk) begin
        if (!rst && data_we) begin
            if (store_count < N_STORES) begin
                check_store(store_count, data_addr, data_wdata, expected[store_count]);
            end else begin
                $display("extra store of %h to %h at %0t, none was expected",
                         data_wdata, data_addr, $time);
                tests_failed++;
            end
            store_count++;
            ram[data_addr[7:2]] <= data_wdata;
        end
    end

    initial begin
        rst          = 1'b1;
        cpu_en       = 1'b1;
        store_count  = 0;
        tests_passed = 0;
        tests_failed = 0;
        cycle        = 0;
        load_program();
        for (int i = 0; i < 64; i++) begin
            rom[i] = (i < PROG_LEN) ? prog[i] : 32'h0;
            ram[i] = 32'h0;
        end
        pause_start = 15 + int'((lcg_next(32) >> 16) % 15);
        repeat (8) @(negedge clk);
        rst = 1'b0;

        while (store_count < N_STORES && cycle < CYCLE_LIMIT) begin
            @(negedge clk);
            cycle++;
            cpu_en = !(cycle >= pause_start && cycle < pause_start + PAUSE_LEN);
        end
        cpu_en = 1'b1;

        if (store_count < N_STORES) begin
            $display("cycle limit of %0d reached with only %0d of %0d stores seen",
                     CYCLE_LIMIT, store_count, N_STORES);
            tests_failed++;
        end else begin
            // let any stray store show up, then catch pc on the loop itself
            repeat (12) @(negedge clk);
            if (pc == LOOP_PC + 32'd4) begin
                @(negedge clk);
            end
            check_pc(pc, LOOP_PC);
        end

        $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire
